// File: rib_pkg.sv
`default_nettype none

package rib_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 32;
    localparam int NUM_SLAVES   = 5;

    localparam int REGION_W     = 4;   // top nibble picks the region
    localparam int MEM_OFS_W    = 14;  // 16 KiB memory windows
    localparam int PERIPH_OFS_W = 28;

    ////////////////////////////////////////////////////////////////////////////
    // address map
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [REGION_W-1:0] REGION_MEM   = 4'h0;  // 0x0xxx_xxxx
    localparam logic [REGION_W-1:0] REGION_UART  = 4'h1;  // 0x1xxx_xxxx
    localparam logic [REGION_W-1:0] REGION_GPIO  = 4'h2;  // 0x2xxx_xxxx
    localparam logic [REGION_W-1:0] REGION_TIMER = 4'h3;  // 0x3xxx_xxxx

    // address bits 15:14 inside the memory region
    localparam logic [1:0] MEM_SEL_ROM = 2'd0;  // 0x0000_0000 .. 0x0000_3fff
    localparam logic [1:0] MEM_SEL_RAM = 2'd1;  // 0x0000_4000 .. 0x0000_7fff

    // slave numbers, also the index into the slave-side arrays
    localparam logic [2:0] SLV_ROM   = 3'd0;
    localparam logic [2:0] SLV_RAM   = 3'd1;
    localparam logic [2:0] SLV_UART  = 3'd2;
    localparam logic [2:0] SLV_GPIO  = 3'd3;
    localparam logic [2:0] SLV_TIMER = 3'd4;

    ////////////////////////////////////////////////////////////////////////////
    // bus address, read through whichever view the region calls for
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [REGION_W-1:0]  region;
        logic [11:0]          rsvd;    // ignored by the decoder
        logic [1:0]           sel;     // rom / ram
        logic [MEM_OFS_W-1:0] ofs;
    } mem_addr_t;

    typedef struct packed {
        logic [REGION_W-1:0]     region;
        logic [PERIPH_OFS_W-1:0] ofs;
    } periph_addr_t;

    typedef union packed {
        mem_addr_t    mem;
        periph_addr_t periph;
    } bus_addr_t;

endpackage

`default_nettype wire

// File: rib_write_arbiter.sv
`default_nettype none

// fixed priority write grant, debug master over load/store
module rib_write_arbiter
    import rib_pkg::*;
(
    // master 0, load/store unit
    input  wire logic              m0_wr_en_i,
    input  wire bus_addr_t         m0_wr_addr_i,
    input  wire logic [DATA_W-1:0] m0_wr_data_i,

    // master 1, debug
    input  wire logic              m1_wr_req_i,
    input  wire logic              m1_wr_en_i,
    input  wire bus_addr_t         m1_wr_addr_i,
    input  wire logic [DATA_W-1:0] m1_wr_data_i,

    // granted write, fanned out to every slave port
    output logic                   wr_en_o,
    output bus_addr_t              wr_addr_o,
    output logic [DATA_W-1:0]      wr_data_o,

    output logic                   hold_o        // stalls the pipeline
);

    always_comb begin
        if (m1_wr_req_i) begin
            // debug owns the bus, core must wait
            wr_en_o   = m1_wr_en_i;
            wr_addr_o = m1_wr_addr_i;
            wr_data_o = m1_wr_data_i;
            hold_o    = 1'b1;
        end else begin
            // load/store is the default owner, no request needed
            wr_en_o   = m0_wr_en_i;
            wr_addr_o = m0_wr_addr_i;
            wr_data_o = m0_wr_data_i;
            hold_o    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rib_slave_port.sv
`default_nettype none

// one slave window: address match, offset strip and output gating
module rib_slave_port
    import rib_pkg::*;
#(
    parameter logic [2:0] SLAVE_IDX = SLV_ROM
) (
    // granted write from the arbiter
    input  wire logic              wr_en_i,
    input  wire bus_addr_t         wr_addr_i,
    input  wire logic [DATA_W-1:0] wr_data_i,

    // master 0 read address
    input  wire bus_addr_t         rd_addr_i,

    // slave side
    output logic                   s_wr_en_o,
    output logic [ADDR_W-1:0]      s_wr_addr_o,
    output logic [DATA_W-1:0]      s_wr_data_o,
    output logic [ADDR_W-1:0]      s_rd_addr_o,

    output logic                   rd_hit_o      // to the read return
);

    ////////////////////////////////////////////////////////////////////////////
    // decode helpers
    ////////////////////////////////////////////////////////////////////////////

    // true when the address falls in this port's window
    function automatic logic addr_match(input bus_addr_t a);
        logic [2:0] slv;
        logic       valid;
        valid = 1'b1;
        slv   = SLV_ROM;
        case (a.periph.region)
            REGION_MEM: begin
                // memory region is split again on bits 15:14
                case (a.mem.sel)
                    MEM_SEL_ROM: slv = SLV_ROM;
                    MEM_SEL_RAM: slv = SLV_RAM;
                    default:     valid = 1'b0;  // hole in the map
                endcase
            end
            REGION_UART:  slv = SLV_UART;
            REGION_GPIO:  slv = SLV_GPIO;
            REGION_TIMER: slv = SLV_TIMER;
            default:      valid = 1'b0;
        endcase
        return valid && (slv == SLAVE_IDX);
    endfunction

    // local offset inside the window, zero extended
    function automatic logic [ADDR_W-1:0] local_ofs(input bus_addr_t a);
        logic [ADDR_W-1:0] ofs;
        if (a.mem.region == REGION_MEM) begin
            ofs = {{(ADDR_W-MEM_OFS_W){1'b0}}, a.mem.ofs};
        end else begin
            ofs = {{(ADDR_W-PERIPH_OFS_W){1'b0}}, a.periph.ofs};
        end
        return ofs;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // gating
    ////////////////////////////////////////////////////////////////////////////

    logic wr_hit;
    logic rd_hit;

    assign wr_hit = addr_match(wr_addr_i);
    assign rd_hit = addr_match(rd_addr_i);

    always_comb begin
        s_wr_en_o   = 1'b0;
        s_wr_addr_o = '0;
        s_wr_data_o = '0;
        if (wr_hit) begin
            s_wr_en_o   = wr_en_i;
            s_wr_addr_o = local_ofs(wr_addr_i);
            s_wr_data_o = wr_data_i;
        end
    end

    // read address goes out unregistered, slave answers next cycle
    always_comb begin
        s_rd_addr_o = '0;
        if (rd_hit) begin
            s_rd_addr_o = local_ofs(rd_addr_i);
        end
    end

    assign rd_hit_o = rd_hit;

endmodule

`default_nettype wire

// File: rib_read_return.sv
`default_nettype none

// read data return for master 0, one cycle behind the address
module rib_read_return
    import rib_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_i,

    input  wire logic [NUM_SLAVES-1:0] rd_hit_i,     // one-hot or zero
    input  wire logic [DATA_W-1:0]     s_rd_data_i [NUM_SLAVES],

    output logic [DATA_W-1:0]          m0_rd_data_o
);

    // which slave the previous read address hit
    logic [NUM_SLAVES-1:0] rd_hit_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_hit_q <= '0;
        end else begin
            rd_hit_q <= rd_hit_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data select
    ////////////////////////////////////////////////////////////////////////////

    // and-or mux, hit vector is at most one-hot so no priority needed
    always_comb begin
        m0_rd_data_o = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (rd_hit_q[i]) begin
                m0_rd_data_o = m0_rd_data_o | s_rd_data_i[i];
            end
        end
        // unmapped read leaves it at zero
    end

endmodule

`default_nettype wire

// File: rib_top.sv
`default_nettype none

// rib system bus, two masters onto five slaves
module rib_top
    import rib_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_i,

    ////////////////////////////////////////////////////////////////////////////
    // master 0, load/store
    ////////////////////////////////////////////////////////////////////////////

    input  wire logic                  m0_wr_en_i,
    input  wire logic [ADDR_W-1:0]     m0_wr_addr_i,
    input  wire logic [DATA_W-1:0]     m0_wr_data_i,
    input  wire logic [ADDR_W-1:0]     m0_rd_addr_i,
    output logic [DATA_W-1:0]          m0_rd_data_o,   // one cycle after addr

    ////////////////////////////////////////////////////////////////////////////
    // master 1, debug (write only)
    ////////////////////////////////////////////////////////////////////////////

    input  wire logic                  m1_wr_req_i,
    input  wire logic                  m1_wr_en_i,
    input  wire logic [ADDR_W-1:0]     m1_wr_addr_i,
    input  wire logic [DATA_W-1:0]     m1_wr_data_i,

    ////////////////////////////////////////////////////////////////////////////
    // slaves, indexed by slave number
    ////////////////////////////////////////////////////////////////////////////

    output logic [NUM_SLAVES-1:0]      s_wr_en_o,
    output logic [ADDR_W-1:0]          s_wr_addr_o [NUM_SLAVES],
    output logic [DATA_W-1:0]          s_wr_data_o [NUM_SLAVES],
    output logic [ADDR_W-1:0]          s_rd_addr_o [NUM_SLAVES],
    input  wire logic [DATA_W-1:0]     s_rd_data_i [NUM_SLAVES],

    output logic                       hold_o          // pipeline stall
);

    // granted write
    logic                  wr_en;
    bus_addr_t             wr_addr;
    logic [DATA_W-1:0]     wr_data;

    // read address match per slave
    logic [NUM_SLAVES-1:0] rd_hit;

    rib_write_arbiter u_write_arbiter (
        .m0_wr_en_i   (m0_wr_en_i),
        .m0_wr_addr_i (m0_wr_addr_i),
        .m0_wr_data_i (m0_wr_data_i),
        .m1_wr_req_i  (m1_wr_req_i),
        .m1_wr_en_i   (m1_wr_en_i),
        .m1_wr_addr_i (m1_wr_addr_i),
        .m1_wr_data_i (m1_wr_data_i),
        .wr_en_o      (wr_en),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .hold_o       (hold_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // slave ports
    ////////////////////////////////////////////////////////////////////////////

    for (genvar n = 0; n < NUM_SLAVES; n++) begin : g_slave
        rib_slave_port #(
            .SLAVE_IDX (3'(n))
        ) u_slave_port (
            .wr_en_i     (wr_en),
            .wr_addr_i   (wr_addr),
            .wr_data_i   (wr_data),
            .rd_addr_i   (m0_rd_addr_i),   // only master 0 reads
            .s_wr_en_o   (s_wr_en_o[n]),
            .s_wr_addr_o (s_wr_addr_o[n]),
            .s_wr_data_o (s_wr_data_o[n]),
            .s_rd_addr_o (s_rd_addr_o[n]),
            .rd_hit_o    (rd_hit[n])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // read return
    ////////////////////////////////////////////////////////////////////////////

    rib_read_return u_read_return (
        .clk          (clk),
        .rst_i        (rst_i),
        .rd_hit_i     (rd_hit),
        .s_rd_data_i  (s_rd_data_i),
        .m0_rd_data_o (m0_rd_data_o)
    );

endmodule

`default_nettype wire

// File: tb_rib_asserts.sv
`default_nettype none

// bus-level properties of rib_top
module tb_rib_asserts
    import rib_pkg::*;
(
    input wire logic                  clk,
    input wire logic                  rst_i,
    input wire logic                  m1_wr_req_i,
    input wire logic                  hold_o,
    input wire logic [NUM_SLAVES-1:0] s_wr_en_o,
    input wire logic [DATA_W-1:0]     m0_rd_data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // windows never overlap
    one_write_enable: assert property (@(posedge clk) $onehot0(s_wr_en_o))
        else $error("several slave write enables high: %b", s_wr_en_o);

    hold_follows_debug_req: assert property (@(posedge clk) hold_o == m1_wr_req_i)
        else $error("hold_o %b while m1_wr_req_i %b", hold_o, m1_wr_req_i);

    // hit vector cleared by reset
    read_data_zero_after_reset: assert property (@(posedge clk) rst_i |=> m0_rd_data_o == '0)
        else $error("m0_rd_data_o %h after reset", m0_rd_data_o);

endmodule

bind rib_top tb_rib_asserts u_rib_asserts (
    .clk          (clk),
    .rst_i        (rst_i),
    .m1_wr_req_i  (m1_wr_req_i),
    .hold_o       (hold_o),
    .s_wr_en_o    (s_wr_en_o),
    .m0_rd_data_o (m0_rd_data_o)
);

`default_nettype wire

// File: tb_rib.sv
`default_nettype none

module tb_rib
    import rib_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD        = 40;
    localparam int RESET_CYCLES  = 2;
    localparam int IDLE_CYCLES   = 3;
    localparam int WIN_COUNT     = 6;
    localparam int PRIO_CYCLES   = 4;
    localparam int HOLE_COUNT    = 5;
    localparam int RANDOM_CYCLES = 200;
    localparam int NUM_TESTS     = 5;
    localparam int MARGIN_CYCLES = 20;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + WIN_COUNT + PRIO_CYCLES
                                 + HOLE_COUNT + RANDOM_CYCLES + NUM_TESTS;

    // one per window and the last has junk in the unused bits
    localparam logic [ADDR_W-1:0] WIN_ADDRS [WIN_COUNT] = '{
        32'h0000_1234, 32'h0000_5678, 32'h1234_5678,
        32'h2abc_def0, 32'h3000_0ffc, 32'h0fff_3fff
    };
    localparam logic [ADDR_W-1:0] HOLE_ADDRS [HOLE_COUNT] = '{
        32'h0000_8000, 32'h0000_c004, 32'h4000_0000, 32'hf123_4567, 32'h8000_0010
    };

    logic                  clk = 1'b0;
    logic                  rst_i;
    logic                  m0_wr_en_i;
    logic [ADDR_W-1:0]     m0_wr_addr_i;
    logic [DATA_W-1:0]     m0_wr_data_i;
    logic [ADDR_W-1:0]     m0_rd_addr_i;
    logic [DATA_W-1:0]     m0_rd_data_o;
    logic                  m1_wr_req_i;
    logic                  m1_wr_en_i;
    logic [ADDR_W-1:0]     m1_wr_addr_i;
    logic [DATA_W-1:0]     m1_wr_data_i;
    logic [NUM_SLAVES-1:0] s_wr_en_o;
    logic [ADDR_W-1:0]     s_wr_addr_o [NUM_SLAVES];
    logic [DATA_W-1:0]     s_wr_data_o [NUM_SLAVES];
    logic [ADDR_W-1:0]     s_rd_addr_o [NUM_SLAVES];
    logic [DATA_W-1:0]     s_rd_data_i [NUM_SLAVES] = '{default: '0};
    logic                  hold_o;

    integer            seed = 46504;
    int                checks = 0;
    int                errors = 0;
    int                tests_run = 0;
    logic [ADDR_W-1:0] prev_rd_addr = '0;
    logic              prev_valid = 1'b0;   // previous read not under reset

    rib_top rib_top_i (
        .clk          (clk),
        .rst_i        (rst_i),
        .m0_wr_en_i   (m0_wr_en_i),
        .m0_wr_addr_i (m0_wr_addr_i),
        .m0_wr_data_i (m0_wr_data_i),
        .m0_rd_addr_i (m0_rd_addr_i),
        .m0_rd_data_o (m0_rd_data_o),
        .m1_wr_req_i  (m1_wr_req_i),
        .m1_wr_en_i   (m1_wr_en_i),
        .m1_wr_addr_i (m1_wr_addr_i),
        .m1_wr_data_i (m1_wr_data_i),
        .s_wr_en_o    (s_wr_en_o),
        .s_wr_addr_o  (s_wr_addr_o),
        .s_wr_data_o  (s_wr_data_o),
        .s_rd_addr_o  (s_rd_addr_o),
        .s_rd_data_i  (s_rd_data_i),
        .hold_o       (hold_o)
    );

    always #(PERIOD/2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // slave model and reference
    ////////////////////////////////////////////////////////////////////////////

    // per-slave tag in the top nibble xor the offset
    function automatic logic [DATA_W-1:0] model_data(input int n, input logic [ADDR_W-1:0] ofs);
        return {4'(n + 8), 28'h5a5_0000} ^ ofs;
    endfunction

    always @(posedge clk) begin
        for (int n = 0; n < NUM_SLAVES; n++) begin
            s_rd_data_i[n] <= model_data(n, s_rd_addr_o[n]);  // synchronous ram read
        end
    end

    // slave number for an address or -1 when unmapped
    function automatic int expected_slave(input logic [ADDR_W-1:0] a,
                                          output logic [ADDR_W-1:0] ofs);
        int slv;
        slv = -1;
        ofs = {4'h0, a[27:0]};
        case (a[31:28])
            4'h0: begin
                ofs = {18'h0, a[13:0]};
                if (a[15:14] == 2'd0)
                    slv = 0;
                else if (a[15:14] == 2'd1)
                    slv = 1;
            end
            4'h1: slv = 2;
            4'h2: slv = 3;
            4'h3: slv = 4;
            default: slv = -1;
        endcase
        return slv;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("[FAIL] %0d ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare a quarter period after each falling edge
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic              we;
        logic [ADDR_W-1:0] wa;
        logic [DATA_W-1:0] wd;
        logic [ADDR_W-1:0] wofs;
        logic [ADDR_W-1:0] rofs;
        logic [ADDR_W-1:0] pofs;
        logic [DATA_W-1:0] exp_rd;
        int                wslv;
        int                rslv;
        int                pslv;
        #(PERIOD/4);
        if (m1_wr_req_i) begin      // debug wins
            we = m1_wr_en_i;
            wa = m1_wr_addr_i;
            wd = m1_wr_data_i;
        end else begin
            we = m0_wr_en_i;
            wa = m0_wr_addr_i;
            wd = m0_wr_data_i;
        end
        wslv = expected_slave(wa, wofs);
        rslv = expected_slave(m0_rd_addr_i, rofs);
        pslv = prev_valid ? expected_slave(prev_rd_addr, pofs) : -1;
        exp_rd = (pslv >= 0) ? model_data(pslv, pofs) : '0;

        if (hold_o !== m1_wr_req_i)
            report_mismatch("hold_o", 32'(hold_o), 32'(m1_wr_req_i));
        if (m0_rd_data_o !== exp_rd)
            report_mismatch("m0_rd_data_o", m0_rd_data_o, exp_rd);
        for (int n = 0; n < NUM_SLAVES; n++) begin
            if (s_wr_en_o[n] !== ((n == wslv) ? we : 1'b0))
                report_mismatch($sformatf("s_wr_en_o[%0d]", n), 32'(s_wr_en_o[n]),
                                32'((n == wslv) ? we : 1'b0));
            if (s_wr_addr_o[n] !== ((n == wslv) ? wofs : '0))
                report_mismatch($sformatf("s_wr_addr_o[%0d]", n), s_wr_addr_o[n],
                                (n == wslv) ? wofs : '0);
            if (s_wr_data_o[n] !== ((n == wslv) ? wd : '0))
                report_mismatch($sformatf("s_wr_data_o[%0d]", n), s_wr_data_o[n],
                                (n == wslv) ? wd : '0);
            if (s_rd_addr_o[n] !== ((n == rslv) ? rofs : '0))
                report_mismatch($sformatf("s_rd_addr_o[%0d]", n), s_rd_addr_o[n],
                                (n == rslv) ? rofs : '0);
        end
        checks += 2 + 4 * NUM_SLAVES;
        prev_rd_addr = m0_rd_addr_i;
        prev_valid   = !rst_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic bus_idle();
        m0_wr_en_i   = 1'b0;
        m0_wr_addr_i = '0;
        m0_wr_data_i = '0;
        m0_rd_addr_i = '0;
        m1_wr_req_i  = 1'b0;
        m1_wr_en_i   = 1'b0;
        m1_wr_addr_i = '0;
        m1_wr_data_i = '0;
    endtask

    // lands in every region and in the holes
    task automatic random_addr(output logic [ADDR_W-1:0] a);
        logic [31:0] r;
        logic [31:0] rk;
        r  = $random(seed);
        rk = $random(seed);
        case (rk[2:0])
            3'd0:    a = {4'h0, r[27:16], 2'd0, r[13:0]};
            3'd1:    a = {4'h0, r[27:16], 2'd1, r[13:0]};
            3'd2:    a = {4'h1, r[27:0]};
            3'd3:    a = {4'h2, r[27:0]};
            3'd4:    a = {4'h3, r[27:0]};
            3'd5:    a = {4'h0, r[27:16], 1'b1, r[14], r[13:0]};  // sel 2 or 3
            3'd6:    a = {1'b1, r[30:0]};
            default: a = {2'b01, r[29:0]};
        endcase
    endtask

    // one extra cycle so the last read comes back and gets checked
    task automatic close_test(input string name, input int errors_before);
        @(negedge clk);
        #(PERIOD/4 + 2);
        tests_run++;
        if (errors == errors_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    endtask

    initial begin
        int          err_before;
        logic [31:0] rnd;
        rst_i = 1'b1;
        bus_idle();

        err_before = errors;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_i = 1'b0;
        repeat (IDLE_CYCLES) @(negedge clk);
        close_test("reset and idle", err_before);

        err_before = errors;
        for (int i = 0; i < WIN_COUNT; i++) begin
            @(negedge clk);
            m0_wr_en_i   = 1'b1;
            m0_wr_addr_i = WIN_ADDRS[i];
            m0_wr_data_i = 32'hd0a0_0000 + 32'(i);
            m0_rd_addr_i = WIN_ADDRS[i];
        end
        close_test("master 0 writes to every window", err_before);

        err_before = errors;
        @(negedge clk);
        m0_wr_addr_i = 32'h0000_4010;
        m0_wr_data_i = 32'h2222_2222;
        m1_wr_req_i  = 1'b1;
        m1_wr_en_i   = 1'b1;
        m1_wr_addr_i = 32'h1000_0040;
        m1_wr_data_i = 32'h1111_1111;
        @(negedge clk);
        m1_wr_addr_i = 32'h3000_0008;
        @(negedge clk);
        m1_wr_en_i   = 1'b0;            // bus held but no write
        @(negedge clk);
        m1_wr_req_i  = 1'b0;
        close_test("debug master priority and hold", err_before);

        err_before = errors;
        for (int i = 0; i < HOLE_COUNT; i++) begin
            @(negedge clk);
            m0_wr_addr_i = HOLE_ADDRS[i];
            m0_rd_addr_i = HOLE_ADDRS[i];
        end
        close_test("unmapped addresses", err_before);

        err_before = errors;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(negedge clk);
            random_addr(m0_rd_addr_i);
            random_addr(m0_wr_addr_i);
            rnd = $random(seed);
            m0_wr_data_i = rnd;
            m0_wr_en_i   = rnd[7];
        end
        close_test("back-to-back random reads", err_before);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * PERIOD);
        $display("watchdog: the run did not finish within %0d cycles",
                 TOTAL_CYCLES + MARGIN_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
rib_pkg.sv
rib_write_arbiter.sv
rib_slave_port.sv
rib_read_return.sv
rib_top.sv
tb_rib_asserts.sv
tb_rib.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the rib testbench with verilator, run it, then look for the pass line
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rib -f build.f -o sim_rib \
    && ./obj_dir/sim_rib 2>&1 | tee sim.log \
    || { echo "run_sim: build or simulation failed"; exit 1; }

grep -qx "TESTS PASSED" sim.log \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
